// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath width in bits
`define XLEN 32

// instruction memory depth in 32-bit words
`define IMEM_WORDS 64

// data memory size in bytes
`define DMEM_BYTES 256

// address of the first instruction fetched after reset
`define RESET_PC 32'h0000_0000

`endif

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // base opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_RTYPE  = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_JALR   = 7'b1100111,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } aluOp_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11
    } resultSrc_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } immSrc_e;

    typedef enum logic [1:0] {
        W_WORD = 2'b00,
        W_HALF = 2'b01,
        W_BYTE = 2'b10
    } dataWidth_e;

endpackage

`default_nettype wire

// File: source/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic [31:0]          instr,
    input  logic                 zero,
    output logic                 jalr,
    output logic                 memWrite,
    output logic                 regWrite,
    output logic                 pcSelect,
    output logic                 aluSrc,
    output cpu_pkg::resultSrc_e  resultSrc,
    output cpu_pkg::immSrc_e     immSrc,
    output cpu_pkg::aluOp_e      aluCtrl,
    output cpu_pkg::dataWidth_e  dataWidth,
    output logic                 loadUnsigned
);

    cpu_pkg::opcode_e opcode;
    logic [2:0]       funct3;
    logic             funct7b5;

    assign opcode   = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb
    begin
        // anything not matched below behaves as a no-op
        jalr         = 1'b0;
        memWrite     = 1'b0;
        regWrite     = 1'b0;
        pcSelect     = 1'b0;
        aluSrc       = 1'b0;
        resultSrc    = cpu_pkg::RES_ALU;
        immSrc       = cpu_pkg::IMM_I;
        aluCtrl      = cpu_pkg::ALU_ADD;
        dataWidth    = cpu_pkg::W_WORD;
        loadUnsigned = 1'b0;

        case (opcode)
            cpu_pkg::OP_RTYPE:
            begin
                regWrite = 1'b1;
                aluCtrl  = cpu_pkg::aluOp_e'({funct7b5, funct3});
            end
            cpu_pkg::OP_IMM:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                // bit 30 is part of the immediate except for SRLI/SRAI
                if (funct3 == 3'b101)
                    aluCtrl = cpu_pkg::aluOp_e'({funct7b5, funct3});
                else
                    aluCtrl = cpu_pkg::aluOp_e'({1'b0, funct3});
            end
            cpu_pkg::OP_LOAD:
            begin
                aluSrc       = 1'b1;                    // base + offset
                resultSrc    = cpu_pkg::RES_MEM;
                loadUnsigned = funct3[2];               // LBU, LHU
                regWrite     = 1'b1;
                case (funct3[1:0])
                    2'b00:   dataWidth = cpu_pkg::W_BYTE;
                    2'b01:   dataWidth = cpu_pkg::W_HALF;
                    2'b10:   dataWidth = cpu_pkg::W_WORD;
                    default: regWrite  = 1'b0;          // no such load
                endcase
                if (funct3 == 3'b110)
                    regWrite = 1'b0;                    // LWU is RV64 only
            end
            cpu_pkg::OP_STORE:
            begin
                aluSrc = 1'b1;
                immSrc = cpu_pkg::IMM_S;
                case (funct3)
                    3'b000:
                    begin
                        memWrite  = 1'b1;
                        dataWidth = cpu_pkg::W_BYTE;
                    end
                    3'b001:
                    begin
                        memWrite  = 1'b1;
                        dataWidth = cpu_pkg::W_HALF;
                    end
                    3'b010:  memWrite = 1'b1;
                    default: memWrite = 1'b0;
                endcase
            end
            cpu_pkg::OP_BRANCH:
            begin
                immSrc = cpu_pkg::IMM_B;
                // SUB for equality, SLT/SLTU give 1 when rs1 < rs2
                case (funct3)
                    3'b000:  {aluCtrl, pcSelect} = {cpu_pkg::ALU_SUB, zero};
                    3'b001:  {aluCtrl, pcSelect} = {cpu_pkg::ALU_SUB, ~zero};
                    3'b100:  {aluCtrl, pcSelect} = {cpu_pkg::ALU_SLT, ~zero};
                    3'b101:  {aluCtrl, pcSelect} = {cpu_pkg::ALU_SLT, zero};
                    3'b110:  {aluCtrl, pcSelect} = {cpu_pkg::ALU_SLTU, ~zero};
                    3'b111:  {aluCtrl, pcSelect} = {cpu_pkg::ALU_SLTU, zero};
                    default: pcSelect = 1'b0;
                endcase
            end
            cpu_pkg::OP_JAL:
            begin
                pcSelect  = 1'b1;                       // pc + immExt
                immSrc    = cpu_pkg::IMM_J;
                resultSrc = cpu_pkg::RES_PC4;
                regWrite  = 1'b1;
            end
            cpu_pkg::OP_JALR:
            begin
                jalr      = 1'b1;
                pcSelect  = 1'b1;                       // target from ALU
                aluSrc    = 1'b1;
                resultSrc = cpu_pkg::RES_PC4;
                regWrite  = 1'b1;
            end
            cpu_pkg::OP_LUI:
            begin
                immSrc    = cpu_pkg::IMM_U;
                resultSrc = cpu_pkg::RES_IMM;
                regWrite  = 1'b1;
            end
            default:
            begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/immExtend.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module immExtend (
    input  logic [31:0]       instr,
    input  cpu_pkg::immSrc_e  immSrc,
    output logic [`XLEN-1:0]  immExt
);

    logic signBit;

    assign signBit = instr[31];                         // sign is always bit 31

    always_comb
    begin
        case (immSrc)
            cpu_pkg::IMM_I:
                immExt = {{(`XLEN-12){signBit}}, instr[31:20]};
            cpu_pkg::IMM_S:
                immExt = {{(`XLEN-12){signBit}}, instr[31:25], instr[11:7]};
            cpu_pkg::IMM_B:
                // branch offsets are in halfwords
                immExt = {{(`XLEN-13){signBit}}, signBit, instr[7],
                          instr[30:25], instr[11:8], 1'b0};
            cpu_pkg::IMM_J:
                immExt = {{(`XLEN-21){signBit}}, signBit, instr[19:12],
                          instr[20], instr[30:21], 1'b0};
            cpu_pkg::IMM_U:
                immExt = {instr[31:12], 12'b0};         // low 12 bits stay zero
            default:
                immExt = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module alu (
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  cpu_pkg::aluOp_e   aluCtrl,
    output logic [`XLEN-1:0]  result,
    output logic              zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];                              // only low five bits shift

    always_comb
    begin
        result = '0;
        case (aluCtrl)
            cpu_pkg::ALU_ADD:  result = a + b;
            cpu_pkg::ALU_SUB:  result = a - b;
            cpu_pkg::ALU_SLL:  result = a << shamt;
            cpu_pkg::ALU_SLT:  result[0] = $signed(a) < $signed(b);
            cpu_pkg::ALU_SLTU: result[0] = a < b;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_SRL:  result = a >> shamt;
            cpu_pkg::ALU_SRA:  result = $signed(a) >>> shamt;   // keeps sign
            cpu_pkg::ALU_OR:   result = a | b;
            cpu_pkg::ALU_AND:  result = a & b;
            default:           result = a + b;
        endcase
    end

    // branch resolution reads this
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module regFile (
    input  logic              clk,
    input  logic              reset,
    input  logic              writeEnable,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic [4:0]        rd,
    input  logic [`XLEN-1:0]  writeData,
    output logic [`XLEN-1:0]  rs1Data,
    output logic [`XLEN-1:0]  rs2Data
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (writeEnable && (rd != 5'd0))           // x0 never written
        begin
            regs[rd] <= writeData;
        end
    end

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

`default_nettype wire

// File: source/instrMem.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module instrMem (
    input  logic              clk,
    input  logic              loadWrite,
    input  logic [`XLEN-1:0]  loadAddr,
    input  logic [31:0]       loadData,
    input  logic [`XLEN-1:0]  addr,
    output logic [31:0]       instr
);

    localparam int ADDR_BITS = $clog2(`IMEM_WORDS);

    logic [31:0] mem [`IMEM_WORDS];

    // program image arrives as byte addresses, stored one word per entry
    always_ff @(posedge clk)
    begin
        if (loadWrite)
            mem[loadAddr[ADDR_BITS+1:2]] <= loadData;
    end

    assign instr = mem[addr[ADDR_BITS+1:2]];            // byte address / 4

endmodule

`default_nettype wire

// File: source/dataMem.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module dataMem (
    input  logic                 clk,
    input  logic                 writeEnable,
    input  logic [`XLEN-1:0]     addr,
    input  logic [`XLEN-1:0]     writeData,
    input  cpu_pkg::dataWidth_e  dataWidth,
    input  logic                 loadUnsigned,
    output logic [`XLEN-1:0]     readData
);

    localparam int ADDR_BITS = $clog2(`DMEM_BYTES);

    logic [7:0]           mem [`DMEM_BYTES];
    logic [ADDR_BITS-1:0] a0;
    logic [ADDR_BITS-1:0] a1;
    logic [ADDR_BITS-1:0] a2;
    logic [ADDR_BITS-1:0] a3;
    logic [31:0]          word;

    assign a0 = addr[ADDR_BITS-1:0];
    assign a1 = a0 + 1'b1;                              // wraps at the top
    assign a2 = a0 + 2'd2;
    assign a3 = a0 + 2'd3;

    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            mem[a0] <= writeData[7:0];
            if (dataWidth != cpu_pkg::W_BYTE)
                mem[a1] <= writeData[15:8];
            if (dataWidth == cpu_pkg::W_WORD)
            begin
                mem[a2] <= writeData[23:16];
                mem[a3] <= writeData[31:24];
            end
        end
    end

    assign word = {mem[a3], mem[a2], mem[a1], mem[a0]};  // little-endian

    always_comb
    begin
        case (dataWidth)
            cpu_pkg::W_BYTE:
                readData = loadUnsigned ? {{(`XLEN-8){1'b0}}, word[7:0]}
                                        : {{(`XLEN-8){word[7]}}, word[7:0]};
            cpu_pkg::W_HALF:
                readData = loadUnsigned ? {{(`XLEN-16){1'b0}}, word[15:0]}
                                        : {{(`XLEN-16){word[15]}}, word[15:0]};
            default:
                readData = word;
        endcase
    end

endmodule

`default_nettype wire

// File: source/cpuCore.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpuCore (
    input  logic              clk,
    input  logic              reset,
    input  logic              progWrite,
    input  logic [`XLEN-1:0]  progAddr,
    input  logic [31:0]       progData,
    output logic [`XLEN-1:0]  pc,
    output logic              wbEnable,
    output logic [4:0]        wbReg,
    output logic [`XLEN-1:0]  wbData,
    output logic              memStore,
    output logic [`XLEN-1:0]  memAddr,
    output logic [`XLEN-1:0]  memStoreData
);

    logic [31:0]          instr;
    logic                 jalr;
    logic                 memWrite;
    logic                 regWrite;
    logic                 pcSelect;
    logic                 aluSrc;
    cpu_pkg::resultSrc_e  resultSrc;
    cpu_pkg::immSrc_e     immSrc;
    cpu_pkg::aluOp_e      aluCtrl;
    cpu_pkg::dataWidth_e  dataWidth;
    logic                 loadUnsigned;
    logic [`XLEN-1:0]     rs1Data;
    logic [`XLEN-1:0]     rs2Data;
    logic [`XLEN-1:0]     immExt;
    logic [`XLEN-1:0]     aluB;
    logic [`XLEN-1:0]     aluResult;
    logic                 zero;
    logic [`XLEN-1:0]     readData;
    logic [`XLEN-1:0]     pcPlus4;
    logic [`XLEN-1:0]     pcNext;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `RESET_PC;
        else
            pc <= pcNext;
    end

    assign pcPlus4 = pc + 3'd4;
    assign pcNext  = !pcSelect ? pcPlus4
                   : jalr      ? {aluResult[`XLEN-1:1], 1'b0}   // JALR clears bit 0
                   :             pc + immExt;

    assign aluB = aluSrc ? immExt : rs2Data;

    always_comb
    begin
        case (resultSrc)
            cpu_pkg::RES_MEM: wbData = readData;
            cpu_pkg::RES_PC4: wbData = pcPlus4;         // link address
            cpu_pkg::RES_IMM: wbData = immExt;          // LUI
            default:          wbData = aluResult;
        endcase
    end

    // no commits while the program is being loaded
    assign wbEnable     = regWrite & ~reset;
    assign memStore     = memWrite & ~reset;
    assign wbReg        = instr[11:7];
    assign memAddr      = aluResult;
    assign memStoreData = rs2Data;

    instrMem imem (
        .clk(clk), .loadWrite(progWrite), .loadAddr(progAddr), .loadData(progData),
        .addr(pc), .instr(instr)
    );

    controlUnit ctrl (
        .instr(instr), .zero(zero), .jalr(jalr), .memWrite(memWrite),
        .regWrite(regWrite), .pcSelect(pcSelect), .aluSrc(aluSrc),
        .resultSrc(resultSrc), .immSrc(immSrc), .aluCtrl(aluCtrl),
        .dataWidth(dataWidth), .loadUnsigned(loadUnsigned)
    );

    regFile regs (
        .clk(clk), .reset(reset), .writeEnable(wbEnable),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(wbReg),
        .writeData(wbData), .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    immExtend immGen (.instr(instr), .immSrc(immSrc), .immExt(immExt));

    alu aluUnit (
        .a(rs1Data), .b(aluB), .aluCtrl(aluCtrl), .result(aluResult), .zero(zero)
    );

    dataMem dmem (
        .clk(clk), .writeEnable(memStore), .addr(aluResult), .writeData(rs2Data),
        .dataWidth(dataWidth), .loadUnsigned(loadUnsigned), .readData(readData)
    );

endmodule

`default_nettype wire

// File: tb/cpuCore_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_defs.svh"

module cpuCore_tb;

    localparam int PERIOD    = 40;
    localparam int MAX_ROWS  = `IMEM_WORDS;
    localparam int GRP_RESET = 0;
    localparam int GRP_ALU   = 1;
    localparam int GRP_STORE = 2;
    localparam int GRP_LOAD  = 3;
    localparam int GRP_BRAN  = 4;
    localparam int GRP_JUMP  = 5;

    logic        clk;
    logic        reset;
    logic        progWrite;
    logic [31:0] progAddr;
    logic [31:0] progData;
    logic [31:0] pc;
    logic        wbEnable;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        memStore;
    logic [31:0] memAddr;
    logic [31:0] memStoreData;

    // program image and the expected retirement of each executed word
    logic [31:0] progMem [MAX_ROWS];
    logic [31:0] expPc [MAX_ROWS];
    logic        expWe [MAX_ROWS];
    logic [4:0]  expRd [MAX_ROWS];
    logic [31:0] expData [MAX_ROWS];
    logic        expSt [MAX_ROWS];
    logic [31:0] expAddr [MAX_ROWS];
    logic [31:0] expSdata [MAX_ROWS];
    int          rowGroup [MAX_ROWS];
    int          progLen;
    int          rowCount;
    int          curGroup;
    bit          tablesReady;

    // architectural state of the reference model
    logic [31:0] refReg [32];
    logic [7:0]  refMem [`DMEM_BYTES];
    logic [31:0] refPc;
    integer      seed;

    int    checkCount;
    int    errorCount;
    int    groupChecks;
    int    groupErrors;
    string groupName [6] = '{"reset", "alu", "store", "load", "branch", "jump"};

    cpuCore UUT (
        .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
        .progData(progData), .pc(pc), .wbEnable(wbEnable), .wbReg(wbReg),
        .wbData(wbData), .memStore(memStore), .memAddr(memAddr),
        .memStoreData(memStoreData)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OP_RTYPE};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input cpu_pkg::opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_pkg::OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpu_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpu_pkg::OP_JAL};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, cpu_pkg::OP_LUI};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I integer semantics with alt as funct7 bit 5
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] here();
        return 32'(progLen * 4);                        // address of the next word
    endfunction

    // adds a word; it retires only if the model reaches its address
    task automatic appendInstr(input logic [31:0] word, input logic we, input logic [4:0] rd,
                               input logic [31:0] data, input logic st,
                               input logic [31:0] addr, input logic [31:0] sdata,
                               input logic [31:0] nextPc);
        logic [31:0] at;
        at = here();
        progMem[progLen] = word;
        progLen++;
        if (at == refPc)
        begin
            expPc[rowCount]    = at;
            expWe[rowCount]    = we;
            expRd[rowCount]    = rd;
            expData[rowCount]  = data;
            expSt[rowCount]    = st;
            expAddr[rowCount]  = addr;
            expSdata[rowCount] = sdata;
            rowGroup[rowCount] = curGroup;
            rowCount++;
            if (we && rd != 5'd0)
                refReg[rd] = data;
            refPc = nextPc;
        end
    endtask

    task automatic regOp(input logic alt, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        appendInstr(encR({1'b0, alt, 5'b0}, rs2, rs1, f3, rd), 1'b1, rd,
                    aluRef(f3, alt, refReg[rs1], refReg[rs2]), 1'b0, 0, 0, here() + 4);
    endtask

    task automatic immOp(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'd5) && imm[10];                  // only SRAI uses the alt bit
        appendInstr(encI(imm, rs1, f3, rd, cpu_pkg::OP_IMM), 1'b1, rd,
                    aluRef(f3, alt, refReg[rs1], sext12(imm)), 1'b0, 0, 0, here() + 4);
    endtask

    // LUI then ADDI with the upper part rounded for the signed low half
    task automatic setReg(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = (val + 32'h800) >> 12;
        appendInstr(encU(upper[19:0], rd), 1'b1, rd, {upper[19:0], 12'b0},
                    1'b0, 0, 0, here() + 4);
        immOp(3'd0, rd, rd, val[11:0]);
    endtask

    task automatic storeOp(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
                           input logic [11:0] imm);
        logic [31:0] addr;
        logic [31:0] val;
        addr = refReg[rs1] + sext12(imm);
        val  = refReg[rs2];
        if (here() == refPc)
        begin
            refMem[addr[7:0]] = val[7:0];
            if (f3 != 3'd0)
                refMem[addr[7:0] + 8'd1] = val[15:8];
            if (f3 == 3'd2)
            begin
                refMem[addr[7:0] + 8'd2] = val[23:16];
                refMem[addr[7:0] + 8'd3] = val[31:24];
            end
        end
        appendInstr(encS(imm, rs2, rs1, f3), 1'b0, 5'd0, 0, 1'b1, addr, val, here() + 4);
    endtask

    task automatic loadOp(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic [31:0] addr;
        logic [31:0] w;
        logic [31:0] data;
        addr = refReg[rs1] + sext12(imm);
        w = {refMem[addr[7:0] + 8'd3], refMem[addr[7:0] + 8'd2],
             refMem[addr[7:0] + 8'd1], refMem[addr[7:0]]};
        case (f3)
            3'd0:    data = {{24{w[7]}}, w[7:0]};
            3'd1:    data = {{16{w[15]}}, w[15:0]};
            3'd4:    data = {24'b0, w[7:0]};
            3'd5:    data = {16'b0, w[15:0]};
            default: data = w;
        endcase
        appendInstr(encI(imm, rs1, f3, rd, cpu_pkg::OP_LOAD), 1'b1, rd, data,
                    1'b0, 0, 0, here() + 4);
    endtask

    // branch over one filler word that retires only when not taken
    task automatic branchOp(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        a = refReg[rs1];
        b = refReg[rs2];
        case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = $signed(a) < $signed(b);
            3'd5:    taken = $signed(a) >= $signed(b);
            3'd6:    taken = a < b;
            default: taken = a >= b;
        endcase
        appendInstr(encB(13'd8, rs2, rs1, f3), 1'b0, 5'd0, 0, 1'b0, 0, 0,
                    taken ? here() + 8 : here() + 4);
        immOp(3'd0, 5'd31, 5'd31, 12'h001);
    endtask

    task automatic buildTables();
        logic [31:0] valA;
        logic [31:0] valB;
        logic [31:0] valC;
        logic [31:0] target;
        seed     = 32'h2cf5_f01b;
        progLen  = 0;
        rowCount = 0;
        refPc    = `RESET_PC;
        for (int i = 0; i < 32; i++)
            refReg[i] = '0;
        for (int i = 0; i < `DMEM_BYTES; i++)
            refMem[i] = '0;
        valA = $random(seed);
        valB = $random(seed) & 32'h7fff_ffff;            // positive
        valC = $random(seed) | 32'h8080_8080;            // every byte has its top bit set

        curGroup = GRP_ALU;
        setReg(5'd1, valA);
        setReg(5'd2, valB);
        setReg(5'd3, valC);
        regOp(1'b0, 3'd0, 5'd4, 5'd1, 5'd2);             // ADD
        regOp(1'b1, 3'd0, 5'd5, 5'd1, 5'd2);             // SUB
        regOp(1'b0, 3'd7, 5'd6, 5'd1, 5'd2);
        regOp(1'b0, 3'd6, 5'd7, 5'd1, 5'd2);
        regOp(1'b0, 3'd4, 5'd8, 5'd1, 5'd2);
        regOp(1'b0, 3'd1, 5'd9, 5'd1, 5'd2);             // SLL
        regOp(1'b0, 3'd5, 5'd10, 5'd3, 5'd2);            // SRL
        regOp(1'b1, 3'd5, 5'd11, 5'd3, 5'd2);            // SRA
        regOp(1'b0, 3'd2, 5'd12, 5'd3, 5'd1);
        regOp(1'b0, 3'd3, 5'd13, 5'd3, 5'd1);
        immOp(3'd5, 5'd14, 5'd3, 12'h407);               // SRAI by 7
        immOp(3'd0, 5'd0, 5'd1, 12'h005);                // write to x0
        regOp(1'b0, 3'd0, 5'd15, 5'd0, 5'd2);            // x0 must still read zero

        curGroup = GRP_STORE;
        storeOp(3'd2, 5'd3, 5'd0, 12'h040);
        storeOp(3'd1, 5'd1, 5'd0, 12'h044);
        storeOp(3'd0, 5'd3, 5'd0, 12'h046);
        storeOp(3'd0, 5'd1, 5'd0, 12'h047);

        curGroup = GRP_LOAD;
        loadOp(3'd2, 5'd16, 5'd0, 12'h040);
        loadOp(3'd0, 5'd17, 5'd0, 12'h043);
        loadOp(3'd4, 5'd18, 5'd0, 12'h043);
        loadOp(3'd1, 5'd19, 5'd0, 12'h042);
        loadOp(3'd5, 5'd20, 5'd0, 12'h042);
        loadOp(3'd1, 5'd21, 5'd0, 12'h044);
        loadOp(3'd0, 5'd22, 5'd0, 12'h046);
        loadOp(3'd4, 5'd23, 5'd0, 12'h046);
        loadOp(3'd2, 5'd24, 5'd0, 12'h044);

        // x3 is negative and x2 positive, so signed and unsigned compares disagree
        curGroup = GRP_BRAN;
        branchOp(3'd0, 5'd3, 5'd3);
        branchOp(3'd0, 5'd3, 5'd2);
        branchOp(3'd1, 5'd3, 5'd2);
        branchOp(3'd1, 5'd3, 5'd3);
        branchOp(3'd4, 5'd3, 5'd2);
        branchOp(3'd4, 5'd2, 5'd3);
        branchOp(3'd5, 5'd2, 5'd3);
        branchOp(3'd5, 5'd3, 5'd2);
        branchOp(3'd6, 5'd2, 5'd3);
        branchOp(3'd6, 5'd3, 5'd2);
        branchOp(3'd7, 5'd3, 5'd2);
        branchOp(3'd7, 5'd2, 5'd3);

        curGroup = GRP_JUMP;
        appendInstr(encJ(21'd8, 5'd25), 1'b1, 5'd25, here() + 4, 1'b0, 0, 0, here() + 8);
        immOp(3'd0, 5'd31, 5'd31, 12'h001);              // skipped by JAL
        target = here() + 12;
        immOp(3'd0, 5'd5, 5'd0, 12'(target + 1));        // odd target so JALR must clear bit 0
        appendInstr(encI(12'h000, 5'd5, 3'd0, 5'd26, cpu_pkg::OP_JALR), 1'b1, 5'd26,
                    here() + 4, 1'b0, 0, 0, (refReg[5] + 0) & ~32'd1);
        immOp(3'd0, 5'd31, 5'd31, 12'h001);              // skipped by JALR
        regOp(1'b0, 3'd0, 5'd27, 5'd25, 5'd26);          // landing
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        errorCount++;
        groupErrors++;
    endtask

    task automatic reportGroup(input int grp);
        $display("%s group: %0d checks, %0d errors", groupName[grp], groupChecks, groupErrors);
        groupChecks = 0;
        groupErrors = 0;
    endtask

    initial
    begin
        wait (tablesReady);
        #((16 + progLen + rowCount + 20) * PERIOD);
        $display("timeout: the core did not retire all instructions in time");
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        int resetCycles;
        reset     = 1'b1;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        checkCount  = 0;
        errorCount  = 0;
        groupChecks = 0;
        groupErrors = 0;
        buildTables();
        tablesReady = 1'b1;
        resetCycles = (progLen + 1 > 16) ? progLen + 1 : 16;   // reset stays high until loaded

        for (int k = 0; k < resetCycles; k++)
        begin
            @(posedge clk);
            if (k == 0)
            begin
                // SW at the reset vector until the program overwrites it
                progWrite <= 1'b1;
                progAddr  <= `RESET_PC;
                progData  <= encS(12'h000, 5'd0, 5'd0, 3'd2);
            end
            else if (k <= progLen)
            begin
                progWrite <= 1'b1;
                progAddr  <= 32'((k - 1) * 4);
                progData  <= progMem[k - 1];
            end
            else
            begin
                progWrite <= 1'b0;
            end
            @(negedge clk);
            checkCount++;
            groupChecks++;
            if (pc !== `RESET_PC)
                reportMismatch("pc", `RESET_PC, pc);
            if (wbEnable !== 1'b0)
                reportMismatch("wbEnable", 0, 32'(wbEnable));
            if (memStore !== 1'b0)
                reportMismatch("memStore", 0, 32'(memStore));
        end
        reportGroup(GRP_RESET);

        @(posedge clk);
        progWrite <= 1'b0;
        reset     <= 1'b0;

        // each row is checked mid-cycle before its commit edge
        for (int i = 0; i < rowCount; i++)
        begin
            @(negedge clk);
            checkCount++;
            groupChecks++;
            if (pc !== expPc[i])
                reportMismatch("pc", expPc[i], pc);
            if (wbEnable !== expWe[i])
                reportMismatch("wbEnable", 32'(expWe[i]), 32'(wbEnable));
            if (expWe[i] && wbReg !== expRd[i])
                reportMismatch("wbReg", 32'(expRd[i]), 32'(wbReg));
            if (expWe[i] && wbData !== expData[i])
                reportMismatch("wbData", expData[i], wbData);
            if (memStore !== expSt[i])
                reportMismatch("memStore", 32'(expSt[i]), 32'(memStore));
            if (expSt[i] && memAddr !== expAddr[i])
                reportMismatch("memAddr", expAddr[i], memAddr);
            if (expSt[i] && memStoreData !== expSdata[i])
                reportMismatch("memStoreData", expSdata[i], memStoreData);
            if (i == rowCount - 1 || rowGroup[i + 1] != rowGroup[i])
                reportGroup(rowGroup[i]);
        end

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
source/cpu_pkg.sv
source/controlUnit.sv
source/immExtend.sv
source/alu.sv
source/regFile.sv
source/instrMem.sv
source/dataMem.sv
source/cpuCore.sv
tb/cpuCore_tb.sv

// File: Makefile
# Verilator build of the single-cycle core and its testbench

VERILATOR ?= verilator
TOP       ?= cpuCore_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Testbench passed

SOURCES := $(wildcard source/*.sv include/*.svh tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
